// File: src.f
hw/ipod_bus_pkg.sv
hw/ipod_player_pkg.sv
hw/key_command_decoder.sv
hw/sample_rate_gen.sv
hw/sample_fetch.sv
hw/ipod_player_top.sv
dv/ipod_asserts.sv
dv/ipod_tb.sv

// File: dv/ipod_tb.sv
module ipod_tb
  import ipod_bus_pkg::*, ipod_player_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int P_DEFAULT = 40;
  localparam int P_STEP    = 8;
  localparam int P_MIN     = 24;
  localparam int P_MAX     = 64;
  localparam logic [20:0] END_ADDR = 21'd15;

  // Samples each test waits for, including alignment to mid-word
  localparam int N_TOTAL = 40 + 37 + 11 + 18 + 14;
  localparam int TIMEOUT_CYCLES = N_TOTAL * P_MAX + 200 + 2000;

  // Position of the next sample in the flash image
  typedef struct packed {
    logic [20:0] addr;
    logic        hi;
    logic        second;
  } pos_t;

  logic          CLK_50M = 1'b0;
  logic          rst_n;
  kbd_cmd_t      kbd;
  speed_keys_t   speed_keys;
  axil_ar_t      flash_ar;
  logic          flash_arready;
  axil_r_t       flash_r;
  logic          flash_rready;
  audio_sample_t audio;

  integer seed = 32'h6802e809;
  string  test_name;
  int     sample_count;
  int     cycle;
  int     last_cycle;
  int     spacing_skip;
  int     exp_period;
  logic   exp_playing;
  dir_e   exp_dir;
  pos_t   pos;

  always #10 CLK_50M = ~CLK_50M;

  ipod_player_top #(
    .SAMPLE_PERIOD_DEFAULT (P_DEFAULT),
    .PERIOD_STEP           (P_STEP),
    .PERIOD_MIN            (P_MIN),
    .PERIOD_MAX            (P_MAX),
    .END_WORD_ADDR         (32'(END_ADDR))
  ) dut_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .kbd           (kbd),
    .speed_keys    (speed_keys),
    .flash_ar      (flash_ar),
    .flash_arready (flash_arready),
    .flash_r       (flash_r),
    .flash_rready  (flash_rready),
    .audio         (audio)
  );

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic logic [31:0] flash_word(input logic [20:0] waddr);
    logic [31:0] x;
    x = {11'd0, waddr} * 32'h9E37_79B9;
    x = x ^ (x >> 15) ^ {waddr[7:0], waddr, 3'b101};
    return x;
  endfunction

  function automatic logic [7:0] expected_sample(input pos_t p);
    logic [31:0] w;
    w = flash_word(p.addr);
    return p.hi ? w[31:24] : w[15:8];
  endfunction

  // Half order and address wrap for the sample after p
  function automatic pos_t next_position(input pos_t p, input dir_e d);
    pos_t n;
    n = p;
    if (!p.second)
    begin
      n.second = 1'b1;
      n.hi     = !p.hi;
    end
    else
    begin
      n.second = 1'b0;
      n.hi     = (d == DIR_BWD);
      if (d == DIR_FWD)
        n.addr = (p.addr == END_ADDR) ? 21'd0 : p.addr + 21'd1;
      else
        n.addr = (p.addr == 21'd0) ? END_ADDR : p.addr - 21'd1;
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  always @(dut_i.fetch_i.asserts_i.fail_count)
  begin
    if (dut_i.fetch_i.asserts_i.fail_count != 0)
    begin
      $display("ERROR: an assertion on the flash port or audio output failed");
      $display("Checks failed");
      $fatal(1, "Assertion failure");
    end
  end

  // ==========================================================================
  // Flash slave with random AR and R latency
  // ==========================================================================

  initial
  begin : flash_model
    int          delay;
    logic [20:0] waddr;
    forever
    begin
      @(posedge CLK_50M);
      if (rst_n && flash_ar.arvalid)
      begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge CLK_50M);
        waddr = flash_ar.araddr[FLASH_ADDR_W-1:2];
        flash_arready <= 1'b1;
        @(posedge CLK_50M);
        flash_arready <= 1'b0;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge CLK_50M);
        flash_r <= '{rvalid: 1'b1, rdata: flash_word(waddr), rresp: 2'b00};
        @(posedge CLK_50M);
        while (!flash_rready)
          @(posedge CLK_50M);
        flash_r <= '0;
      end
    end
  end

  // ==========================================================================
  // Tracker and comparison
  // ==========================================================================

  // Sees the commands at the same edge as the DUT
  always @(posedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (rst_n && kbd.valid)
    begin
      case (kbd.code)
        PLAY:
        begin
          exp_playing  = 1'b1;
          spacing_skip = 1;
        end
        STOP:     exp_playing = 1'b0;
        FORWARD:  exp_dir = DIR_FWD;
        BACKWARD: exp_dir = DIR_BWD;
        RESTART:  pos = '{addr: (exp_dir == DIR_FWD) ? 21'd0 : END_ADDR,
                          hi: (exp_dir == DIR_BWD), second: 1'b0};
        default:  ;
      endcase
    end
    // The interval already running keeps the old period
    if (rst_n && (speed_keys != '0))
    begin
      spacing_skip = 1;
      if (speed_keys.reset_speed)
        exp_period = P_DEFAULT;
      else if (speed_keys.faster)
        exp_period = (exp_period - P_STEP < P_MIN) ? P_MIN : exp_period - P_STEP;
      else
        exp_period = (exp_period + P_STEP > P_MAX) ? P_MAX : exp_period + P_STEP;
    end
  end

  always @(negedge CLK_50M)
  begin
    if (rst_n && audio.valid)
    begin
      if (!exp_playing)
        check_value({test_name, " valid while stopped"}, 0, 1);
      check_value(test_name, expected_sample(pos), audio.sample);
      if (spacing_skip > 0)
        spacing_skip--;
      else
        check_value({test_name, " spacing"}, exp_period, cycle - last_cycle);
      last_cycle = cycle;
      pos = next_position(pos, exp_dir);
      sample_count++;
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic send_key(input logic [7:0] key);
    @(posedge CLK_50M);
    kbd <= '{valid: 1'b1, code: key};
    @(posedge CLK_50M);
    kbd <= '{valid: 1'b0, code: 8'h00};
  endtask

  task automatic pulse_speed(input speed_keys_t keys, input int count);
    repeat (count)
    begin
      @(posedge CLK_50M);
      speed_keys <= keys;
    end
    @(posedge CLK_50M);
    speed_keys <= '0;
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = sample_count + n;
    wait (sample_count >= target);
  endtask

  // Direction changes only between the two halves of a word
  task automatic wait_mid_word();
    while (!pos.second)
      wait_samples(1);
  endtask

  initial
  begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge CLK_50M);
    $display("ERROR: watchdog expired after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
    $display("Checks failed");
    $fatal(1, "Watchdog timeout");
  end

  initial
  begin : main
    int count_before;
    rst_n         = 1'b0;
    kbd           = '0;
    speed_keys    = '0;
    flash_arready = 1'b0;
    flash_r       = '0;
    sample_count  = 0;
    cycle         = 0;
    last_cycle    = 0;
    spacing_skip  = 1;
    exp_period    = P_DEFAULT;
    exp_playing   = 1'b0;
    exp_dir       = DIR_FWD;
    pos           = '0;
    test_name     = "reset";
    repeat (3) @(posedge CLK_50M);
    rst_n <= 1'b1;

    test_name = "forward";
    send_key(PLAY);
    wait_samples(2);
    send_key(8'h58);
    wait_samples(38);

    test_name = "backward";
    wait_mid_word();
    send_key(BACKWARD);
    wait_samples(36);

    test_name = "stop_resume";
    send_key(STOP);
    count_before = sample_count;
    repeat (200) @(posedge CLK_50M);
    check_value("stop_resume idle", count_before, sample_count);
    send_key(PLAY);
    wait_samples(10);

    test_name = "restart";
    wait_mid_word();
    send_key(FORWARD);
    wait_samples(3);
    send_key(RESTART);
    wait_samples(4);
    wait_mid_word();
    send_key(BACKWARD);
    wait_samples(3);
    send_key(RESTART);
    wait_samples(4);

    test_name = "speed";
    pulse_speed('{faster: 1'b1, slower: 1'b0, reset_speed: 1'b0}, 4);
    wait_samples(4);
    pulse_speed('{faster: 1'b0, slower: 1'b1, reset_speed: 1'b0}, 6);
    wait_samples(4);
    pulse_speed('{faster: 1'b0, slower: 1'b0, reset_speed: 1'b1}, 1);
    wait_samples(4);

    if (dut_i.fetch_i.asserts_i.fail_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("ERROR: %0d assertion failures", dut_i.fetch_i.asserts_i.fail_count);
      $display("Checks failed");
      $fatal(1, "Assertion failures during the run");
    end
  end

endmodule

// File: dv/ipod_asserts.sv
module ipod_asserts
  import ipod_bus_pkg::*, ipod_player_pkg::*;
(
  input logic          CLK_50M,
  input logic          rst_n,
  input play_ctrl_t    ctrl,
  input axil_ar_t      flash_ar,
  input logic          flash_arready,
  input axil_r_t       flash_r,
  input logic          flash_rready,
  input audio_sample_t audio
);

  timeunit 1ns;
  timeprecision 1ps;

  // Assertion failures so far
  int fail_count = 0;

  // ==========================================================================
  // Flash handshake
  // ==========================================================================

  a_ar_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_ar.arvalid && !flash_arready |=> flash_ar.arvalid && $stable(flash_ar.araddr))
  else
  begin
    fail_count++;
    $error("AR channel changed before arready");
  end

  // Data phase opens only on an AR transfer
  a_rready_after_ar: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    $rose(flash_rready) |-> $past(flash_ar.arvalid && flash_arready))
  else
  begin
    fail_count++;
    $error("rready raised without an AR transfer");
  end

  // No read accepted while a word sits in the holding register
  a_rready_no_hold: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_rready && flash_r.rvalid |=> !flash_rready)
  else
  begin
    fail_count++;
    $error("rready still high after the word was taken");
  end

  // ==========================================================================
  // Audio and control
  // ==========================================================================

  // A sample only leaves if it was picked while playing
  a_quiet_when_stopped: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    audio.valid |-> $past(ctrl.playing))
  else
  begin
    fail_count++;
    $error("Audio sample emitted while stopped");
  end

  a_restart_pulse: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ctrl.restart |=> !ctrl.restart)
  else
  begin
    fail_count++;
    $error("Restart held for more than one cycle");
  end

endmodule

bind sample_fetch ipod_asserts asserts_i (
  .CLK_50M       (CLK_50M),
  .rst_n         (rst_n),
  .ctrl          (ctrl),
  .flash_ar      (flash_ar),
  .flash_arready (flash_arready),
  .flash_r       (flash_r),
  .flash_rready  (flash_rready),
  .audio         (audio)
);

// File: hw/ipod_player_top.sv
module ipod_player_top
  import ipod_bus_pkg::*, ipod_player_pkg::*;
#(
  parameter int          SAMPLE_PERIOD_DEFAULT = 2272,
  parameter int          PERIOD_STEP           = 64,
  parameter int          PERIOD_MIN            = 512,
  parameter int          PERIOD_MAX            = 8192,
  parameter logic [31:0] END_WORD_ADDR         = 32'h7FFFF
)
(
  input  logic          CLK_50M,
  input  logic          rst_n,
  input  kbd_cmd_t      kbd,
  input  speed_keys_t   speed_keys,
  output axil_ar_t      flash_ar,
  input  logic          flash_arready,
  input  axil_r_t       flash_r,
  output logic          flash_rready,
  output audio_sample_t audio
);

  play_ctrl_t ctrl;
  logic       tick;

  // ==========================================================================
  // Control side
  // ==========================================================================

  key_command_decoder decoder_i (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .kbd     (kbd),
    .ctrl    (ctrl)
  );

  sample_rate_gen #(
    .SAMPLE_PERIOD_DEFAULT (SAMPLE_PERIOD_DEFAULT),
    .PERIOD_STEP           (PERIOD_STEP),
    .PERIOD_MIN            (PERIOD_MIN),
    .PERIOD_MAX            (PERIOD_MAX)
  ) rate_gen_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .speed_keys (speed_keys),
    .ctrl       (ctrl),
    .tick       (tick)
  );

  // ==========================================================================
  // Flash to audio
  // ==========================================================================

  sample_fetch #(
    .END_WORD_ADDR (END_WORD_ADDR)
  ) fetch_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .tick          (tick),
    .flash_ar      (flash_ar),
    .flash_arready (flash_arready),
    .flash_r       (flash_r),
    .flash_rready  (flash_rready),
    .audio         (audio)
  );

endmodule

// File: hw/sample_fetch.sv
module sample_fetch
  import ipod_bus_pkg::*, ipod_player_pkg::*;
#(
  parameter logic [31:0] END_WORD_ADDR = 32'h7FFFF
)
(
  input  logic          CLK_50M,
  input  logic          rst_n,
  input  play_ctrl_t    ctrl,
  input  logic          tick,
  output axil_ar_t      flash_ar,
  input  logic          flash_arready,
  input  axil_r_t       flash_r,
  output logic          flash_rready,
  output audio_sample_t audio
);

  // Word address width, byte address drops the two low bits
  localparam int WA_W = FLASH_ADDR_W - 2;
  localparam logic [WA_W-1:0] END_ADDR = END_WORD_ADDR[WA_W-1:0];

  fetch_state_e state;

  logic [WA_W-1:0]         word_addr;
  logic [WA_W-1:0]         step_addr;
  logic [WA_W-1:0]         restart_addr;
  logic [FLASH_DATA_W-1:0] word_q;
  logic [FLASH_DATA_W-1:0] emit_word;
  logic                    hi_next;
  logic                    second_q;
  logic                    tick_pend;
  logic                    restart_pend;
  logic                    restart_hit;
  logic                    r_done;
  logic                    want_emit;
  logic                    emit_from_r;
  logic                    emit_from_hold;
  logic                    emit;
  logic                    emit_hi;
  logic                    audio_valid_q;
  logic [7:0]              audio_sample_q;

  // ==========================================================================
  // Flash port and address arithmetic
  // ==========================================================================

  // word_addr only moves outside F_ADDR, which keeps araddr stable
  assign flash_ar     = '{arvalid: (state == F_ADDR), araddr: {word_addr, 2'b00}};
  assign flash_rready = (state == F_DATA);

  always_comb
  begin
    if (ctrl.dir == DIR_FWD)
      step_addr = (word_addr == END_ADDR) ? '0 : word_addr + WA_W'(1);
    else
      step_addr = (word_addr == '0) ? END_ADDR : word_addr - WA_W'(1);

    restart_addr = (ctrl.dir == DIR_FWD) ? '0 : END_ADDR;
  end

  // ==========================================================================
  // Emit decision
  // ==========================================================================

  always_comb
  begin
    r_done      = (state == F_DATA) && flash_r.rvalid;
    restart_hit = ctrl.restart || restart_pend;
    want_emit   = ctrl.playing && (tick || tick_pend);

    // A late tick goes out straight from the R beat, first half of the word
    emit_from_r    = r_done && !restart_hit && want_emit;
    emit_from_hold = (state == F_HOLD) && !ctrl.restart && want_emit;
    emit           = emit_from_r || emit_from_hold;

    emit_hi   = emit_from_r ? (ctrl.dir == DIR_BWD) : hi_next;
    emit_word = emit_from_r ? flash_r.rdata : word_q;
  end

  // ==========================================================================
  // Fetch FSM
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= F_IDLE;
      word_addr     <= '0;
      hi_next       <= 1'b0;
      second_q      <= 1'b0;
      tick_pend     <= 1'b0;
      restart_pend  <= 1'b0;
      audio_valid_q <= 1'b0;
    end
    else
    begin
      audio_valid_q <= emit;

      // At most one remembered tick, dropped on stop
      if (!ctrl.playing || emit)
        tick_pend <= 1'b0;
      else if (tick)
        tick_pend <= 1'b1;

      case (state)
        F_IDLE:
        begin
          if (ctrl.restart)
            word_addr <= restart_addr;
          state <= F_ADDR;
        end

        F_ADDR:
        begin
          // Let the AR transfer finish first
          if (ctrl.restart)
            restart_pend <= 1'b1;
          if (flash_arready)
            state <= F_DATA;
        end

        F_DATA:
        begin
          if (flash_r.rvalid)
          begin
            restart_pend <= 1'b0;
            if (restart_hit)
            begin
              // Word thrown away, refetch from the restart point
              word_addr <= restart_addr;
              state     <= F_ADDR;
            end
            else
            begin
              state <= F_HOLD;
              if (emit)
              begin
                second_q <= 1'b1;
                hi_next  <= (ctrl.dir == DIR_FWD);
              end
              else
              begin
                second_q <= 1'b0;
                hi_next  <= (ctrl.dir == DIR_BWD);
              end
            end
          end
          else if (ctrl.restart)
          begin
            restart_pend <= 1'b1;
          end
        end

        F_HOLD:
        begin
          if (ctrl.restart)
          begin
            word_addr <= restart_addr;
            state     <= F_ADDR;
          end
          else if (emit)
          begin
            if (second_q)
            begin
              // Both halves out, next read starts right away
              word_addr <= step_addr;
              state     <= F_ADDR;
            end
            else
            begin
              second_q <= 1'b1;
              hi_next  <= ~hi_next;
            end
          end
        end

        default: state <= F_IDLE;
      endcase
    end
  end

  // Data path
  always_ff @(posedge CLK_50M)
  begin
    if (r_done)
      word_q <= flash_r.rdata;
    if (emit)
      audio_sample_q <= emit_hi ? emit_word[31:24] : emit_word[15:8];
  end

  // Nothing leaves while stopped, even a sample chosen on the last tick
  assign audio = '{valid: audio_valid_q && ctrl.playing, sample: audio_sample_q};

endmodule

// File: hw/sample_rate_gen.sv
module sample_rate_gen
  import ipod_player_pkg::*;
#(
  parameter int SAMPLE_PERIOD_DEFAULT = 2272,
  parameter int PERIOD_STEP           = 64,
  parameter int PERIOD_MIN            = 512,
  parameter int PERIOD_MAX            = 8192
)
(
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  speed_keys_t speed_keys,
  input  play_ctrl_t  ctrl,
  output logic        tick
);

  logic [PERIOD_W-1:0] period;
  logic [PERIOD_W-1:0] period_next;
  logic [PERIOD_W-1:0] count;

  // ==========================================================================
  // Period register
  // ==========================================================================

  // reset_speed beats faster, faster beats slower
  always_comb
  begin
    period_next = period;
    if (speed_keys.reset_speed)
    begin
      period_next = PERIOD_W'(SAMPLE_PERIOD_DEFAULT);
    end
    else if (speed_keys.faster)
    begin
      if (int'(period) - PERIOD_STEP < PERIOD_MIN)
        period_next = PERIOD_W'(PERIOD_MIN);
      else
        period_next = period - PERIOD_W'(PERIOD_STEP);
    end
    else if (speed_keys.slower)
    begin
      if (int'(period) + PERIOD_STEP > PERIOD_MAX)
        period_next = PERIOD_W'(PERIOD_MAX);
      else
        period_next = period + PERIOD_W'(PERIOD_STEP);
    end
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      period <= PERIOD_W'(SAMPLE_PERIOD_DEFAULT);
    else
      period <= period_next;
  end

  // ==========================================================================
  // Tick divider
  // ==========================================================================

  // Parked at the period while stopped, so the first tick lands P cycles in
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= PERIOD_W'(SAMPLE_PERIOD_DEFAULT);
      tick  <= 1'b0;
    end
    else if (!ctrl.playing)
    begin
      count <= period;
      tick  <= 1'b0;
    end
    else if (count == PERIOD_W'(1))
    begin
      // New period picked up here
      count <= period;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - PERIOD_W'(1);
      tick  <= 1'b0;
    end
  end

endmodule

// File: hw/key_command_decoder.sv
module key_command_decoder
  import ipod_player_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  kbd_cmd_t   kbd,
  output play_ctrl_t ctrl
);

  // Decoded command strobes
  logic cmd_play;
  logic cmd_stop;
  logic cmd_fwd;
  logic cmd_bwd;
  logic cmd_restart;

  always_comb
  begin
    cmd_play    = kbd.valid && (kbd.code == PLAY);
    cmd_stop    = kbd.valid && (kbd.code == STOP);
    cmd_fwd     = kbd.valid && (kbd.code == FORWARD);
    cmd_bwd     = kbd.valid && (kbd.code == BACKWARD);
    cmd_restart = kbd.valid && (kbd.code == RESTART);
  end

  // ==========================================================================
  // Player state
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl <= '{playing: 1'b0, dir: DIR_FWD, restart: 1'b0};
    end
    else
    begin
      // One-cycle pulse
      ctrl.restart <= cmd_restart;

      if (cmd_play)
      begin
        ctrl.playing <= 1'b1;
      end
      else if (cmd_stop)
      begin
        ctrl.playing <= 1'b0;
      end

      if (cmd_fwd)
      begin
        ctrl.dir <= DIR_FWD;
      end
      else if (cmd_bwd)
      begin
        ctrl.dir <= DIR_BWD;
      end
    end
  end

endmodule

// File: hw/ipod_player_pkg.sv
package ipod_player_pkg;

  // Period counter width in clock cycles
  localparam int PERIOD_W = 16;

  // ==========================================================================
  // Encodings
  // ==========================================================================

  // ASCII keyboard commands
  typedef enum logic [7:0] {
    PLAY     = 8'h45,  // 'E'
    STOP     = 8'h44,  // 'D'
    FORWARD  = 8'h46,  // 'F'
    BACKWARD = 8'h42,  // 'B'
    RESTART  = 8'h52   // 'R'
  } key_cmd_e;

  typedef enum logic {
    DIR_FWD = 1'b0,
    DIR_BWD = 1'b1
  } dir_e;

  // Flash fetch FSM
  typedef enum logic [1:0] {
    F_IDLE = 2'd0,
    F_ADDR = 2'd1,
    F_DATA = 2'd2,
    F_HOLD = 2'd3
  } fetch_state_e;

  // ==========================================================================
  // Control and data bundles
  // ==========================================================================

  // Raw code, so unknown keys pass through and get ignored
  typedef struct packed {
    logic       valid;
    logic [7:0] code;
  } kbd_cmd_t;

  typedef struct packed {
    logic faster;
    logic slower;
    logic reset_speed;
  } speed_keys_t;

  typedef struct packed {
    logic playing;
    dir_e dir;
    logic restart;
  } play_ctrl_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] sample;
  } audio_sample_t;

endpackage

// File: hw/ipod_bus_pkg.sv
package ipod_bus_pkg;

  // ==========================================================================
  // Flash geometry
  // ==========================================================================

  // Byte address into the flash device
  localparam int FLASH_ADDR_W = 23;

  // One flash word holds two 16-bit samples
  localparam int FLASH_DATA_W = 32;

  // ==========================================================================
  // AXI4-Lite read channels
  // ==========================================================================

  // Read address channel, master to slave
  typedef struct packed {
    logic                    arvalid;
    logic [FLASH_ADDR_W-1:0] araddr;
  } axil_ar_t;

  // Read data channel, slave to master
  // rresp is carried but the player has no use for it
  typedef struct packed {
    logic                    rvalid;
    logic [FLASH_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
  } axil_r_t;

endpackage
